//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_reboot_top
FILELIST  ?= reboot_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- iprog_sequencer.sv
// write-only reload sequencer; avail is checked only at start, boot request must be synchronous
`timescale 1ns/1ps

module iprog_sequencer (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_n_i,
    input  logic                   boot_req_i,
    input  logic                   icap_avail_i,
    output logic                   icap_csib_o,
    output logic                   icap_rdwrb_o,
    output reboot_pkg::icap_word_t icap_di_o
);

    import reboot_pkg::*;

    // each word state names the word currently on the port
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DUMMY,
        ST_SYNC,
        ST_NOOP,
        ST_WRITE_CMD,
        ST_IPROG,
        ST_NOOP_END
    } state_t;

    state_t     state_q;
    logic       csib_q;
    icap_word_t di_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            csib_q  <= 1'b1;
            di_q    <= CMD_DUMMY;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    csib_q <= 1'b1;
                    di_q   <= CMD_DUMMY;
                    if (boot_req_i && icap_avail_i) begin
                        state_q <= ST_DUMMY;
                        csib_q  <= 1'b0;
                    end
                end
                ST_DUMMY: begin
                    state_q <= ST_SYNC;
                    di_q    <= CMD_SYNC;
                end
                ST_SYNC: begin
                    state_q <= ST_NOOP;
                    di_q    <= CMD_NOOP;
                end
                ST_NOOP: begin
                    state_q <= ST_WRITE_CMD;
                    di_q    <= CMD_WRITE_CMD;
                end
                ST_WRITE_CMD: begin
                    state_q <= ST_IPROG;
                    di_q    <= CMD_IPROG;
                end
                ST_IPROG: begin
                    state_q <= ST_NOOP_END;
                    di_q    <= CMD_NOOP;
                end
                default: begin
                    // deselect for one cycle before the next start
                    state_q <= ST_IDLE;
                    csib_q  <= 1'b1;
                    di_q    <= CMD_DUMMY;
                end
            endcase
        end
    end

    assign icap_csib_o  = csib_q;
    // the port is only ever written
    assign icap_rdwrb_o = 1'b0;
    assign icap_di_o    = bit_reverse_bytes(di_q);

endmodule

//--- reboot_pkg.sv
// shared widths and configuration words; the byte bit-reversal matches the configuration port order
package reboot_pkg;

    // push switches
    localparam int SW_CNT = 4;

    typedef logic [SW_CNT-1:0] sw_t;

    // configuration port data width
    localparam int ICAP_W = 32;

    typedef logic [ICAP_W-1:0] icap_word_t;

    // reload command stream
    localparam icap_word_t CMD_DUMMY     = 32'hFFFFFFFF;
    localparam icap_word_t CMD_SYNC      = 32'hAA995566;
    // type 1 no-op
    localparam icap_word_t CMD_NOOP      = 32'h20000000;
    // write one word to the command register
    localparam icap_word_t CMD_WRITE_CMD = 32'h30008001;
    localparam icap_word_t CMD_IPROG     = 32'h0000000F;

    // dummy, sync, noop, write cmd, iprog, noop
    localparam int IPROG_WORD_CNT = 6;

    // the port takes each byte with bit 0 in the msb position
    function automatic icap_word_t bit_reverse_bytes(input icap_word_t word);
        icap_word_t rev;
        for (int b = 0; b < ICAP_W/8; b++) begin
            for (int i = 0; i < 8; i++) begin
                rev[8*b + i] = word[8*b + 7 - i];
            end
        end
        return rev;
    endfunction

endpackage

//--- reboot_top.f
reboot_pkg.sv
reset_sync.sv
signal_sync.sv
switch_debounce.sv
iprog_sequencer.sv
reboot_top.sv
reboot_top_props.sv
tb_reboot_top.sv

//--- reboot_top.sv
// board-support top; clock must already be buffered, boot request and switches may be asynchronous
`timescale 1ns/1ps

module reboot_top #(
    parameter int RST_SYNC_STAGES = 4,
    parameter int SYNC_STAGES     = 2,
    parameter int DEBOUNCE_RATE   = 156000,
    parameter int DEBOUNCE_DEPTH  = 4
) (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_n_i,
    input  reboot_pkg::sw_t        sw_i,
    output reboot_pkg::sw_t        sw_debounced_o,
    input  logic                   boot_req_i,
    input  logic                   icap_avail_i,
    output logic                   icap_csib_o,
    output logic                   icap_rdwrb_o,
    output reboot_pkg::icap_word_t icap_di_o
);

    import reboot_pkg::*;

    logic rst_int_n;
    logic boot_req_sync;
    sw_t  sw_sync;

    reset_sync #(
        .RST_SYNC_STAGES(RST_SYNC_STAGES)
    ) reset_sync_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .rst_sync_n_o  (rst_int_n)
    );

    // reboot request into the core domain
    signal_sync #(
        .T          (logic),
        .SYNC_STAGES(SYNC_STAGES)
    ) boot_sync_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_int_n),
        .data_i        (boot_req_i),
        .data_o        (boot_req_sync)
    );

    signal_sync #(
        .T          (sw_t),
        .SYNC_STAGES(SYNC_STAGES)
    ) sw_sync_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_int_n),
        .data_i        (sw_i),
        .data_o        (sw_sync)
    );

    switch_debounce #(
        .DEBOUNCE_RATE (DEBOUNCE_RATE),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) switch_debounce_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_int_n),
        .sw_i          (sw_sync),
        .sw_o          (sw_debounced_o)
    );

    iprog_sequencer iprog_sequencer_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_int_n),
        .boot_req_i    (boot_req_sync),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_rdwrb_o  (icap_rdwrb_o),
        .icap_di_o     (icap_di_o)
    );

endmodule

//--- reboot_top_props.sv
// checks for reboot_top, bind only; expected port words are the command constants reversed by hand
`timescale 1ns/1ps

module reboot_top_props #(
    parameter int SYNC_STAGES    = 2,
    parameter int DEBOUNCE_RATE  = 156000,
    parameter int DEBOUNCE_DEPTH = 4
) (
    input logic                   clk_125mhz_int,
    input logic                   rst_n_i,
    input logic                   boot_req_i,
    input logic                   boot_req_sync_i,
    input logic                   icap_avail_i,
    input logic                   icap_csib_i,
    input logic                   icap_rdwrb_i,
    input reboot_pkg::icap_word_t icap_di_i,
    input reboot_pkg::sw_t        sw_i,
    input reboot_pkg::sw_t        sw_debounced_i
);

    import reboot_pkg::*;

    localparam int STABLE_LIMIT = (DEBOUNCE_DEPTH + 1) * DEBOUNCE_RATE + SYNC_STAGES;
    localparam int STABLE_W     = $clog2(STABLE_LIMIT + 1);

    // dummy, sync, noop, write cmd, iprog, noop as seen on the port
    localparam icap_word_t EXP_WORDS [IPROG_WORD_CNT] = '{
        32'hFFFFFFFF, 32'h5599AA66, 32'h04000000,
        32'h0C000180, 32'h000000F0, 32'h04000000
    };

    int unsigned         fail_cnt = 0;
    logic [STABLE_W-1:0] stable_cnt [SW_CNT];
    sw_t                 sw_prev_q;

    // saturating count of cycles since each switch input last changed
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SW_CNT; i++) begin
                stable_cnt[i] <= '0;
            end
            sw_prev_q <= '0;
        end else begin
            sw_prev_q <= sw_i;
            for (int i = 0; i < SW_CNT; i++) begin
                if (sw_i[i] != sw_prev_q[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] != STABLE_W'(STABLE_LIMIT)) begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk_125mhz_int) icap_rdwrb_i == 1'b0)
    else begin
        fail_cnt++;
        $error("Fail icap_rdwrb_o got %h expected 0", $sampled(icap_rdwrb_i));
    end

    assert property (@(posedge clk_125mhz_int) !rst_n_i |=>
        icap_csib_i && icap_di_i == EXP_WORDS[0] && sw_debounced_i == '0)
    else begin
        fail_cnt++;
        $error("Fail reset values icap_csib_o %h icap_di_o %h sw_debounced_o %h",
            $sampled(icap_csib_i), $sampled(icap_di_i), $sampled(sw_debounced_i));
    end

    // idle starts on request and avail and otherwise stays deselected
    assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        icap_csib_i && boot_req_sync_i && icap_avail_i |=>
        !icap_csib_i && icap_di_i == EXP_WORDS[0])
    else begin
        fail_cnt++;
        $error("Fail start icap_csib_o %h icap_di_o %h expected 0 and %h",
            $sampled(icap_csib_i), $sampled(icap_di_i), EXP_WORDS[0]);
    end

    assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        icap_csib_i && !(boot_req_sync_i && icap_avail_i) |=>
        icap_csib_i && icap_di_i == EXP_WORDS[0])
    else begin
        fail_cnt++;
        $error("Fail idle icap_csib_o %h icap_di_o %h expected 1 and %h",
            $sampled(icap_csib_i), $sampled(icap_di_i), EXP_WORDS[0]);
    end

    // top-level latency from a request edge to chip select
    assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        $past(boot_req_i, SYNC_STAGES + 1) && !$past(boot_req_i, SYNC_STAGES + 2) &&
        $past(icap_avail_i && icap_csib_i) |-> !icap_csib_i)
    else begin
        fail_cnt++;
        $error("Fail icap_csib_o got %h expected 0 after request", $sampled(icap_csib_i));
    end

    for (genvar k = 1; k < IPROG_WORD_CNT; k++) begin : g_word
        assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
            $past(icap_csib_i, k + 1) && !$past(icap_csib_i, k) |->
            !icap_csib_i && icap_di_i == EXP_WORDS[k])
        else begin
            fail_cnt++;
            $error("Fail word %0d icap_csib_o %h icap_di_o %h expected 0 and %h",
                k, $sampled(icap_csib_i), $sampled(icap_di_i), EXP_WORDS[k]);
        end
    end

    assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        $past(icap_csib_i, IPROG_WORD_CNT + 1) && !$past(icap_csib_i, IPROG_WORD_CNT) |->
        icap_csib_i)
    else begin
        fail_cnt++;
        $error("Fail icap_csib_o got %h expected 1 after last word", $sampled(icap_csib_i));
    end

    for (genvar i = 0; i < SW_CNT; i++) begin : g_sw
        // a change needs DEPTH agreeing samples spaced one tick apart
        for (genvar k = 0; k < DEBOUNCE_DEPTH; k++) begin : g_tick
            assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
                $changed(sw_debounced_i[i]) |->
                $past(sw_i[i], 1 + SYNC_STAGES + k * DEBOUNCE_RATE) == sw_debounced_i[i])
            else begin
                fail_cnt++;
                $error("Fail sw_debounced_o[%0d] changed to %h, sample %0d ticks back differs",
                    i, $sampled(sw_debounced_i[i]), k);
            end
        end

        assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
            stable_cnt[i] == STABLE_W'(STABLE_LIMIT) |-> sw_debounced_i[i] == sw_prev_q[i])
        else begin
            fail_cnt++;
            $error("Fail sw_debounced_o[%0d] got %h expected %h",
                i, $sampled(sw_debounced_i[i]), $sampled(sw_prev_q[i]));
        end
    end

endmodule

//--- reset_sync.sv
// synchronous active-low reset stretcher; needs RST_SYNC_STAGES of at least 2, assertion is seen one edge late
`timescale 1ns/1ps

module reset_sync #(
    parameter int RST_SYNC_STAGES = 4
) (
    input  logic clk_125mhz_int,
    input  logic rst_n_i,
    output logic rst_sync_n_o
);

    logic [RST_SYNC_STAGES-1:0] rst_shift_q;

    // clears at once, fills with ones after release
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            rst_shift_q <= '0;
        end else begin
            rst_shift_q <= {rst_shift_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // last stage drives the internal reset
    assign rst_sync_n_o = rst_shift_q[RST_SYNC_STAGES-1];

endmodule

//--- signal_sync.sv
// register chain synchronizer; multi-bit payloads are not coherent, use only for independent bits
`timescale 1ns/1ps

module signal_sync #(
    parameter type T = logic,
    parameter int SYNC_STAGES = 2
) (
    input  logic clk_125mhz_int,
    input  logic rst_n_i,
    input  T     data_i,
    output T     data_o
);

    T sync_q [SYNC_STAGES];

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            // first stage may go metastable
            sync_q[0] <= data_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign data_o = sync_q[SYNC_STAGES-1];

endmodule

//--- switch_debounce.sv
// sampled switch debouncer; expects synchronized inputs and DEBOUNCE_DEPTH of at least 2
`timescale 1ns/1ps

module switch_debounce #(
    parameter int DEBOUNCE_RATE  = 156000,
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic             clk_125mhz_int,
    input  logic             rst_n_i,
    input  reboot_pkg::sw_t  sw_i,
    output reboot_pkg::sw_t  sw_o
);

    import reboot_pkg::*;

    localparam int CNT_W = (DEBOUNCE_RATE > 1) ? $clog2(DEBOUNCE_RATE) : 1;

    logic [CNT_W-1:0]          rate_cnt_q;
    logic                      tick;
    logic [DEBOUNCE_DEPTH-1:0] hist_q    [SW_CNT];
    logic [DEBOUNCE_DEPTH-1:0] hist_next [SW_CNT];
    sw_t                       sw_q;

    // one sample tick per DEBOUNCE_RATE cycles
    assign tick = (rate_cnt_q == CNT_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            rate_cnt_q <= '0;
        end else if (tick) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 1'b1;
        end
    end

    // history including the sample taken on this tick
    always_comb begin
        for (int i = 0; i < SW_CNT; i++) begin
            hist_next[i] = {hist_q[i][DEBOUNCE_DEPTH-2:0], sw_i[i]};
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SW_CNT; i++) begin
                hist_q[i] <= '0;
            end
            sw_q <= '0;
        end else if (tick) begin
            for (int i = 0; i < SW_CNT; i++) begin
                hist_q[i] <= hist_next[i];
                // change only on a unanimous history, else hold
                if (&hist_next[i]) begin
                    sw_q[i] <= 1'b1;
                end else if (~|hist_next[i]) begin
                    sw_q[i] <= 1'b0;
                end
            end
        end
    end

    assign sw_o = sw_q;

endmodule

//--- tb_reboot_top.sv
// testbench for reboot_top with a fast debounce rate; run with assertions enabled
`timescale 1ns/1ps

module tb_reboot_top;

    import reboot_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int SYNC_STAGES     = 2;
    localparam int DEBOUNCE_RATE   = 8;
    localparam int DEBOUNCE_DEPTH  = 4;
    localparam int SW_ROUNDS       = 8;
    // DEPTH+1 ticks plus the synchronizer and a spare tick
    localparam int HOLD_CYCLES     = (DEBOUNCE_DEPTH + 2) * DEBOUNCE_RATE + SYNC_STAGES;
    localparam int GLITCH_MAX      = (DEBOUNCE_DEPTH - 1) * DEBOUNCE_RATE;
    localparam int BOOT_CYCLES     = 300;
    localparam int TEST_CYCLES     = BOOT_CYCLES + SW_ROUNDS * (2 * HOLD_CYCLES + GLITCH_MAX);
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic        clk_125mhz_int;
    logic        rst_n_i;
    sw_t         sw_i;
    sw_t         sw_debounced_o;
    logic        boot_req_i;
    logic        icap_avail_i;
    logic        icap_csib_o;
    logic        icap_rdwrb_o;
    icap_word_t  icap_di_o;
    logic [31:0] lfsr_state;

    reboot_top #(
        .SYNC_STAGES   (SYNC_STAGES),
        .DEBOUNCE_RATE (DEBOUNCE_RATE),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) dut0 (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .sw_i          (sw_i),
        .sw_debounced_o(sw_debounced_o),
        .boot_req_i    (boot_req_i),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_rdwrb_o  (icap_rdwrb_o),
        .icap_di_o     (icap_di_o)
    );

    bind reboot_top reboot_top_props #(
        .SYNC_STAGES   (SYNC_STAGES),
        .DEBOUNCE_RATE (DEBOUNCE_RATE),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) props_inst (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n_i        (rst_int_n),
        .boot_req_i     (boot_req_i),
        .boot_req_sync_i(boot_req_sync),
        .icap_avail_i   (icap_avail_i),
        .icap_csib_i    (icap_csib_o),
        .icap_rdwrb_i   (icap_rdwrb_o),
        .icap_di_i      (icap_di_o),
        .sw_i           (sw_i),
        .sw_debounced_i (sw_debounced_o)
    );

    task automatic fail_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_csib(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (icap_csib_o !== level) begin
            if (n == max_cycles) begin
                fail_run("configuration chip select did not reach the expected level in time");
            end else begin
                @(negedge clk_125mhz_int);
                n++;
            end
        end
    endtask

    initial begin
        clk_125mhz_int = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125mhz_int = ~clk_125mhz_int;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    always @(negedge clk_125mhz_int) begin
        if (dut0.props_inst.fail_cnt != 0) begin
            fail_run("a property check failed, see the error above");
        end
    end

    initial begin
        logic [31:0] rnd;
        sw_t         settled;
        sw_t         mask;
        int          glitch_len;
        lfsr_state   = 32'h73f446c4;
        rst_n_i      = 1'b0;
        sw_i         = '0;
        boot_req_i   = 1'b0;
        icap_avail_i = 1'b0;
        repeat (5) @(negedge clk_125mhz_int);
        rst_n_i = 1'b1;
        repeat (10) @(negedge clk_125mhz_int);

        // short request with avail dropped once the sequence runs
        icap_avail_i = 1'b1;
        boot_req_i   = 1'b1;
        repeat (2) @(negedge clk_125mhz_int);
        boot_req_i = 1'b0;
        wait_csib(1'b0, 8);
        icap_avail_i = 1'b0;
        wait_csib(1'b1, 10);
        repeat (5) @(negedge clk_125mhz_int);

        // random requests while the port is unavailable
        repeat (40) begin
            draw_bits(1, rnd);
            boot_req_i = rnd[0];
            @(negedge clk_125mhz_int);
        end
        boot_req_i = 1'b1;
        repeat (4) @(negedge clk_125mhz_int);
        icap_avail_i = 1'b1;
        // held request gives back-to-back sequences
        repeat (3) begin
            wait_csib(1'b0, 8);
            wait_csib(1'b1, 10);
        end
        boot_req_i = 1'b0;
        repeat (20) @(negedge clk_125mhz_int);

        for (int r = 0; r < SW_ROUNDS; r++) begin
            draw_bits(SW_CNT, rnd);
            settled = rnd[SW_CNT-1:0];
            sw_i    = settled;
            repeat (HOLD_CYCLES) @(negedge clk_125mhz_int);
            draw_bits(SW_CNT, rnd);
            mask = (rnd[SW_CNT-1:0] == '0) ? sw_t'(1) : rnd[SW_CNT-1:0];
            draw_bits(5, rnd);
            glitch_len = int'(rnd[4:0]) % GLITCH_MAX + 1;
            // at most DEPTH-1 ticks of the flipped value
            sw_i = settled ^ mask;
            repeat (glitch_len) @(negedge clk_125mhz_int);
            sw_i = settled;
            repeat (HOLD_CYCLES) @(negedge clk_125mhz_int);
        end

        repeat (10) @(negedge clk_125mhz_int);
        if (dut0.props_inst.fail_cnt != 0) begin
            fail_run("property checks reported errors");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
